/* dv/red_pitaya_top_assertions.sv */
// system bus protocol assertions and their bind into red_pitaya_top
module red_pitaya_top_assertions
  import rp_pkg::*;
(
  input logic     adc_clk,
  input logic     rst_i,
  input sys_req_t sys_req_i,       // master side request
  input sys_rsp_t sys_rsp_o        // master side response
);

  logic strobe;                    // read or write this cycle

  assign strobe = sys_req_i.wen | sys_req_i.ren;

  a_ack_single: assert property (@(posedge adc_clk) disable iff (rst_i)
    sys_rsp_o.ack |=> !sys_rsp_o.ack) else $error("ack stayed high for two cycles");
  a_err_with_ack: assert property (@(posedge adc_clk) disable iff (rst_i)
    sys_rsp_o.err |-> sys_rsp_o.ack) else $error("err raised without ack");
  a_ack_after_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    strobe |=> sys_rsp_o.ack) else $error("no ack one cycle after strobe");
  a_ack_has_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    sys_rsp_o.ack |-> $past(strobe)) else $error("ack without a strobe before it");
  a_no_strobe_pending: assert property (@(posedge adc_clk) disable iff (rst_i)
    strobe |=> !strobe) else $error("new strobe while an access waits for ack");

endmodule

bind red_pitaya_top red_pitaya_top_assertions i_bus_assertions (
  .adc_clk   (adc_clk),
  .rst_i     (rst_i),
  .sys_req_i (sys_req_i),
  .sys_rsp_o (sys_rsp_o)
);

/* dv/red_pitaya_top_tb.sv */
// testbench for red_pitaya_top with LCG stimulus, reference model, bus tasks and watchdog
`include "rp_params.svh"

module red_pitaya_top_tb
  import rp_pkg::*;
();

  localparam int depth    = `RP_ASG_DEPTH;
  localparam int aw       = $clog2(depth);         // table index bits
  localparam int sw       = `RP_SAMPLE_W;
  localparam int smax     = 2**(sw-1) - 1;
  localparam int smin     = -(2**(sw-1));
  localparam int n_led    = 8;                     // LED write/read rounds
  localparam int n_pid    = 12;                    // controller rounds
  localparam int n_const  = 2;                     // one per ASG channel
  localparam int settle   = 5;                     // pins to DAC is 3 cycles
  localparam int ack_wait = 4;                     // cycles allowed for an ack
  localparam int n_txn    = 1 + 2*n_led + 10 + 8*n_pid + n_const*(2*depth + 6) + depth + 8;
  localparam int wd_cyc   = n_txn*(ack_wait + 2) + (n_pid + n_const + 1)*settle + depth + 55;

  logic                 adc_clk;
  logic                 rst;
  sys_req_t             sys_req;
  sys_rsp_t             sys_rsp;
  logic [sw-1:0]        adc_a;
  logic [sw-1:0]        adc_b;
  logic [sw-1:0]        dac_a;
  logic [sw-1:0]        dac_b;
  logic [7:0]           led;

  logic [31:0]          lcg_state;
  sample_t              tbl [2][depth];            // model copy of the ASG tables
  sample_t              pid_exp [2];               // model controller output

  red_pitaya_top i_dut (
    .adc_clk     (adc_clk),
    .rst_i       (rst),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp),
    .adc_dat_a_i (adc_a),
    .adc_dat_b_i (adc_b),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b),
    .led_o       (led)
  );

  always #2 adc_clk = ~adc_clk;                    // period 4

  // -------------------------------------------------------------------------
  // random numbers and reference model

  function automatic logic [15:0] rnd16();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];                       // upper bits, longer period
  endfunction

  function automatic logic [31:0] reg_addr(int region, logic [19:0] ofs);
    return (32'(region) << `RP_REGION_LSB) | 32'(ofs);
  endfunction

  // top bit kept, low bits inverted, same both ways
  function automatic sample_t code_to_sample(logic [sw-1:0] w);
    return sample_t'({w[sw-1], ~w[sw-2:0]});
  endfunction

  function automatic logic [sw-1:0] sample_to_code(sample_t s);
    return {s[sw-1], ~s[sw-2:0]};
  endfunction

  function automatic sample_t clip(longint v);
    if (v > smax) return sample_t'(smax);
    if (v < smin) return sample_t'(smin);
    return sample_t'(v);
  endfunction

  function automatic sample_t model_p(sample_t sp, sample_t kp, sample_t x);
    longint prod;
    prod = (longint'(sp) - longint'(x)) * longint'(kp);
    return clip(prod >>> `RP_PID_SHIFT);           // floor shift, then clip
  endfunction

  function automatic logic [sw-1:0] model_dac(sample_t asg, sample_t pid);
    return sample_to_code(clip(longint'(asg) + longint'(pid)));
  endfunction

  // -------------------------------------------------------------------------
  // compare tasks

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_rdata(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) stop_run($sformatf("error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) stop_run($sformatf("error: %s err expected %b actual %b", name, exp, act));
  endtask

  task automatic check_code(input string name, input logic [sw-1:0] exp, input logic [sw-1:0] act);
    if (act !== exp) stop_run($sformatf("error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_led(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) stop_run($sformatf("error: %s expected %h actual %h", name, exp, act));
  endtask

  // -------------------------------------------------------------------------
  // bus tasks, entered and left just after a rising edge

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata, input logic wr,
                            output logic [31:0] rdata, output logic err);
    int n;
    n = 0;
    sys_req = '{addr: addr, wdata: wdata, wen: wr, ren: !wr};
    @(posedge adc_clk);
    #1;
    sys_req.wen = 1'b0;                            // one cycle strobe
    sys_req.ren = 1'b0;
    while (!sys_rsp.ack) begin
      if (n == ack_wait) stop_run($sformatf("no ack for address %h", addr));
      n++;
      @(posedge adc_clk);
      #1;
    end
    rdata = sys_rsp.rdata;                         // address still held here
    err   = sys_rsp.err;
    @(posedge adc_clk);                            // idle cycle after ack
    #1;
  endtask

  task automatic read_expect(input string name, input logic [31:0] addr,
                             input logic [31:0] exp, input logic exp_err);
    logic [31:0] rd;
    logic        er;
    bus_access(addr, 32'h0, 1'b0, rd, er);
    check_err(name, exp_err, er);
    check_rdata(name, exp, rd);
  endtask

  task automatic write_expect(input string name, input logic [31:0] addr,
                              input logic [31:0] data, input logic exp_err);
    logic [31:0] rd;
    logic        er;
    bus_access(addr, data, 1'b1, rd, er);
    check_err(name, exp_err, er);
    check_rdata(name, 32'h0, rd);                  // writes answer with zero data
  endtask

  task automatic wait_settle();
    repeat (settle) @(posedge adc_clk);
    #1;
  endtask

  // -------------------------------------------------------------------------
  // watchdog

  initial begin
    #(wd_cyc * 4);
    $display("error: watchdog expired after %0d cycles, a test did not finish", wd_cyc);
    $display("Result: FAILED");
    $fatal(1, "watchdog");
  end

  // -------------------------------------------------------------------------
  // test sequence

  initial begin
    logic [15:0]   r;
    logic [7:0]    led_v;
    sample_t       sp [2];
    sample_t       kp [2];
    logic [sw-1:0] raw [2];
    sample_t       smp;
    int            unm [5];
    int            step;
    int            i0;
    int            ix;
    adc_clk   = 1'b0;
    rst       = 1'b1;
    sys_req   = '0;
    adc_a     = '0;
    adc_b     = '0;
    lcg_state = 32'd89;
    unm       = '{1, 4, 5, 6, 7};
    repeat (5) @(posedge adc_clk);
    #1 rst = 1'b0;

    // reset state of the pins
    check_led("led after reset", 8'h0, led);
    check_code("dac a after reset", sample_to_code('0), dac_a);
    check_code("dac b after reset", sample_to_code('0), dac_b);

    // housekeeping
    read_expect("hk id read", reg_addr(`RP_HK_REGION, 'h00), `RP_HK_ID, 1'b0);
    for (int i = 0; i < n_led; i++) begin
      r     = rnd16();
      led_v = r[7:0];
      write_expect("hk led write", reg_addr(`RP_HK_REGION, 'h30), {24'h0, led_v}, 1'b0);
      check_led("hk led pins", led_v, led);
      read_expect("hk led read", reg_addr(`RP_HK_REGION, 'h30), {24'h0, led_v}, 1'b0);
    end

    // unmapped regions and slave errors
    for (int i = 0; i < 5; i++) begin
      r = rnd16();
      read_expect("unmapped read", reg_addr(unm[i], {2'b00, r, 2'b00}), 32'h0, 1'b0);
    end
    read_expect("hk undefined offset", reg_addr(`RP_HK_REGION, 'h04), 32'h0, 1'b1);
    read_expect("asg undefined offset", reg_addr(`RP_ASG_REGION, 'h0c), 32'h0, 1'b1);
    read_expect("pid undefined offset", reg_addr(`RP_PID_REGION, 'h08), 32'h0, 1'b1);
    write_expect("hk id write", reg_addr(`RP_HK_REGION, 'h00), 32'h1234_5678, 1'b1);
    read_expect("hk id after write", reg_addr(`RP_HK_REGION, 'h00), `RP_HK_ID, 1'b0);

    // controller path, ASG idle since reset
    for (int i = 0; i < n_pid; i++) begin
      for (int ch = 0; ch < 2; ch++) begin
        r       = rnd16();
        sp[ch]  = sample_t'(r[sw-1:0]);
        r       = rnd16();
        kp[ch]  = sample_t'(r[sw-1:0]);
        if (i % 2 == 0) kp[ch] = kp[ch] >>> 6;     // small gain, no clipping
        r       = rnd16();
        raw[ch] = r[sw-1:0];
        write_expect("pid setpoint write", reg_addr(`RP_PID_REGION, 20'(ch*16)),
                     32'(sp[ch]), 1'b0);
        write_expect("pid gain write", reg_addr(`RP_PID_REGION, 20'(ch*16 + 4)),
                     32'(kp[ch]), 1'b0);
        read_expect("pid setpoint read", reg_addr(`RP_PID_REGION, 20'(ch*16)),
                    32'(sp[ch]), 1'b0);
        read_expect("pid gain read", reg_addr(`RP_PID_REGION, 20'(ch*16 + 4)),
                    32'(kp[ch]), 1'b0);
        pid_exp[ch] = model_p(sp[ch], kp[ch], code_to_sample(raw[ch]));
      end
      adc_a = raw[0];
      adc_b = raw[1];
      wait_settle();
      check_code("pid path dac a", model_dac('0, pid_exp[0]), dac_a);
      check_code("pid path dac b", model_dac('0, pid_exp[1]), dac_b);
    end

    // ASG with step 0, controller term still applied
    for (int c = 0; c < n_const; c++) begin
      write_expect("asg ctrl off", reg_addr(`RP_ASG_REGION, 'h00), 32'h0, 1'b0);
      write_expect("asg step a", reg_addr(`RP_ASG_REGION, 'h04), 32'h0, 1'b0);
      write_expect("asg step b", reg_addr(`RP_ASG_REGION, 'h08), 32'h0, 1'b0);
      for (int idx = 0; idx < depth; idx++) begin
        for (int ch = 0; ch < 2; ch++) begin
          r = rnd16();
          tbl[ch][idx] = sample_t'(r[sw-1:0]);
          write_expect("asg table write", reg_addr(`RP_ASG_REGION, 20'('h10000*(ch+1) + 4*idx)),
                       32'(tbl[ch][idx]), 1'b0);
        end
      end
      r  = rnd16();
      ix = int'(r[aw-1:0]);
      read_expect("asg table read", reg_addr(`RP_ASG_REGION, 20'('h10000*(c+1) + 4*ix)),
                  32'(tbl[c][ix]), 1'b0);
      write_expect("asg ctrl on", reg_addr(`RP_ASG_REGION, 'h00), 32'(1 << c), 1'b0);
      read_expect("asg ctrl read", reg_addr(`RP_ASG_REGION, 'h00), 32'(1 << c), 1'b0);
      wait_settle();
      check_code("asg const dac a", model_dac(c == 0 ? tbl[0][0] : '0, pid_exp[0]), dac_a);
      check_code("asg const dac b", model_dac(c == 1 ? tbl[1][0] : '0, pid_exp[1]), dac_b);
    end

    // ASG sweep on channel a, gains zero
    write_expect("pid gain a zero", reg_addr(`RP_PID_REGION, 'h04), 32'h0, 1'b0);
    write_expect("pid gain b zero", reg_addr(`RP_PID_REGION, 'h14), 32'h0, 1'b0);
    write_expect("asg ctrl off", reg_addr(`RP_ASG_REGION, 'h00), 32'h0, 1'b0);
    r    = rnd16();
    step = (r[aw-1:0] == 0) ? 1 : int'(r[aw-1:0]);
    write_expect("asg step a", reg_addr(`RP_ASG_REGION, 'h04), 32'(step), 1'b0);
    read_expect("asg step a read", reg_addr(`RP_ASG_REGION, 'h04), 32'(step), 1'b0);
    r    = rnd16();                                // channel b stays disabled
    write_expect("asg step b", reg_addr(`RP_ASG_REGION, 'h08), 32'(r[aw-1:0]), 1'b0);
    read_expect("asg step b read", reg_addr(`RP_ASG_REGION, 'h08), 32'(r[aw-1:0]), 1'b0);
    for (int idx = 0; idx < depth; idx++) begin
      r = rnd16();
      tbl[0][idx] = sample_t'({idx[aw-1:0], r[sw-aw-1:0]});   // index in the top bits
      write_expect("asg table write", reg_addr(`RP_ASG_REGION, 20'('h10000 + 4*idx)),
                   32'(tbl[0][idx]), 1'b0);
    end
    write_expect("asg ctrl a on", reg_addr(`RP_ASG_REGION, 'h00), 32'h1, 1'b0);
    wait_settle();
    smp = code_to_sample(dac_a);
    i0  = int'(smp[sw-1 -: aw]);                   // first observed entry
    for (int k = 0; k < depth; k++) begin
      ix = (i0 + k*step) % depth;
      check_code("asg sweep dac a", sample_to_code(tbl[0][ix]), dac_a);
      check_code("asg sweep dac b", sample_to_code('0), dac_b);
      @(posedge adc_clk);
      #1;
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* logic/red_pitaya_top.sv */
// top level with system bus decoder, housekeeping, ASG, controller and analog block
`include "rp_params.svh"

module red_pitaya_top
  import rp_pkg::*;
(
  input  logic                    adc_clk,       // single core clock
  input  logic                    rst_i,
  input  sys_req_t                sys_req_i,     // bus master request
  output sys_rsp_t                sys_rsp_o,
  input  logic [`RP_SAMPLE_W-1:0] adc_dat_a_i,   // raw ADC words
  input  logic [`RP_SAMPLE_W-1:0] adc_dat_b_i,
  output logic [`RP_SAMPLE_W-1:0] dac_dat_a_o,   // DAC codes
  output logic [`RP_SAMPLE_W-1:0] dac_dat_b_o,
  output logic [7:0]              led_o
);

  sys_req_t     hk_req;        // steered requests
  sys_req_t     asg_req;
  sys_req_t     pid_req;
  sys_rsp_t     hk_rsp;        // slave responses
  sys_rsp_t     asg_rsp;
  sys_rsp_t     pid_rsp;

  sample_pair_t adc_s;         // converted ADC pair
  sample_pair_t asg_s;         // generator pair
  sample_pair_t pid_s;         // controller pair

  // -------------------------------------------------------------------------
  // system bus

  rp_sys_decoder i_dec (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),
    .asg_req_o (asg_req),
    .pid_req_o (pid_req),
    .hk_rsp_i  (hk_rsp),
    .asg_rsp_i (asg_rsp),
    .pid_rsp_i (pid_rsp)
  );

  rp_hk i_hk (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .sys_req_i (hk_req),
    .sys_rsp_o (hk_rsp),
    .led_o     (led_o)
  );

  // -------------------------------------------------------------------------
  // signal path

  rp_asg i_asg (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .sys_req_i (asg_req),
    .sys_rsp_o (asg_rsp),
    .asg_o     (asg_s)
  );

  rp_pid i_pid (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .sys_req_i (pid_req),
    .sys_rsp_o (pid_rsp),
    .adc_i     (adc_s),
    .pid_o     (pid_s)
  );

  rp_analog i_analog (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_o       (adc_s),
    .asg_i       (asg_s),
    .pid_i       (pid_s),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

/* logic/rp_analog.sv */
// ADC input conversion and DAC sum, saturation and encoding
`include "rp_params.svh"

module rp_analog
  import rp_pkg::*;
(
  input  logic                    adc_clk,
  input  logic                    rst_i,
  input  logic [`RP_SAMPLE_W-1:0] adc_dat_a_i,   // raw, unsigned negative slope
  input  logic [`RP_SAMPLE_W-1:0] adc_dat_b_i,
  output sample_pair_t            adc_o,         // two's complement
  input  sample_pair_t            asg_i,
  input  sample_pair_t            pid_i,
  output logic [`RP_SAMPLE_W-1:0] dac_dat_a_o,   // DAC code per channel
  output logic [`RP_SAMPLE_W-1:0] dac_dat_b_o
);

  localparam sample_t smax = {1'b0, {(`RP_SAMPLE_W-1){1'b1}}};  // +8191
  localparam sample_t smin = {1'b1, {(`RP_SAMPLE_W-1){1'b0}}};  // -8192

  // same bit mapping both ways, top bit kept and the rest inverted
  function automatic logic [`RP_SAMPLE_W-1:0] flip(logic [`RP_SAMPLE_W-1:0] w);
    return {w[`RP_SAMPLE_W-1], ~w[`RP_SAMPLE_W-2:0]};
  endfunction

  function automatic sample_t sat_sum(sample_t x, sample_t y);
    logic signed [`RP_SAMPLE_W:0] s;              // one bit of headroom
    s = x + y;
    if (s[`RP_SAMPLE_W -: 2] == 2'b01) return smax;  // positive overflow
    if (s[`RP_SAMPLE_W -: 2] == 2'b10) return smin;  // negative overflow
    return s[`RP_SAMPLE_W-1:0];
  endfunction

  // -------------------------------------------------------------------------
  // ADC input register

  always_ff @(posedge adc_clk) begin
    adc_o <= '{a: flip(adc_dat_a_i), b: flip(adc_dat_b_i)};
  end

  // -------------------------------------------------------------------------
  // DAC output register

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dac_dat_a_o <= flip('0);                     // code of a zero sample
      dac_dat_b_o <= flip('0);
    end else begin
      dac_dat_a_o <= flip(sat_sum(asg_i.a, pid_i.a));
      dac_dat_b_o <= flip(sat_sum(asg_i.b, pid_i.b));
    end
  end

endmodule

/* logic/rp_asg.sv */
// arbitrary signal generator with two waveform tables, playback pointers and control registers
`include "rp_params.svh"

module rp_asg
  import rp_pkg::*;
(
  input  logic         adc_clk,
  input  logic         rst_i,
  input  sys_req_t     sys_req_i,  // strobes already steered
  output sys_rsp_t     sys_rsp_o,  // registered, one cycle
  output sample_pair_t asg_o       // generator samples to the DAC sum
);

  localparam int aw = $clog2(`RP_ASG_DEPTH);       // pointer and step width

  localparam logic [`RP_REGION_LSB-1:0] ctrl_ofs   = 'h00000;  // channel enables
  localparam logic [`RP_REGION_LSB-1:0] step_a_ofs = 'h00004;
  localparam logic [`RP_REGION_LSB-1:0] step_b_ofs = 'h00008;
  localparam logic [`RP_REGION_LSB-1:0] tbl_a_ofs  = 'h10000;  // 4 bytes per entry
  localparam logic [`RP_REGION_LSB-1:0] tbl_b_ofs  = 'h20000;

  logic [`RP_REGION_LSB-1:0] ofs;
  logic [aw-1:0]             idx;        // table entry from the address
  logic                      strobe;
  logic                      hit_ctrl;
  logic [1:0]                hit_step;   // one per channel
  logic [1:0]                hit_tbl;
  logic                      bad;        // no register at this offset
  logic [31:0]               rd_data;

  logic [1:0]                en;         // bit 0 channel a, bit 1 channel b
  logic [aw-1:0]             step [2];
  sample_t                   tbl_rd [2]; // bus read port of each table
  sample_t                   out [2];    // playback samples

  // -------------------------------------------------------------------------
  // register decode

  assign ofs      = sys_req_i.addr[`RP_REGION_LSB-1:0];
  assign idx      = ofs[aw+1:2];
  assign strobe   = sys_req_i.wen | sys_req_i.ren;
  assign hit_ctrl = (ofs == ctrl_ofs);
  assign hit_step = {ofs == step_b_ofs, ofs == step_a_ofs};
  assign hit_tbl[0] = (ofs[`RP_REGION_LSB-1:aw+2] == tbl_a_ofs[`RP_REGION_LSB-1:aw+2]) &&
                      (ofs[1:0] == 2'b00);
  assign hit_tbl[1] = (ofs[`RP_REGION_LSB-1:aw+2] == tbl_b_ofs[`RP_REGION_LSB-1:aw+2]) &&
                      (ofs[1:0] == 2'b00);
  assign bad      = !(hit_ctrl || (|hit_step) || (|hit_tbl));

  always_comb begin
    rd_data = 32'h0;
    if (sys_req_i.ren && !bad) begin
      if (hit_ctrl)         rd_data = {30'h0, en};
      else if (hit_step[0]) rd_data = {{(32-aw){1'b0}}, step[0]};
      else if (hit_step[1]) rd_data = {{(32-aw){1'b0}}, step[1]};
      else if (hit_tbl[0])  rd_data = 32'(tbl_rd[0]);   // sign extended
      else                  rd_data = 32'(tbl_rd[1]);
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      en        <= 2'b00;                     // both channels idle
      step[0]   <= '0;
      step[1]   <= '0;
      sys_rsp_o <= '0;
    end else begin
      if (sys_req_i.wen && hit_ctrl)    en      <= sys_req_i.wdata[1:0];
      if (sys_req_i.wen && hit_step[0]) step[0] <= sys_req_i.wdata[aw-1:0];
      if (sys_req_i.wen && hit_step[1]) step[1] <= sys_req_i.wdata[aw-1:0];
      sys_rsp_o.ack   <= strobe;
      sys_rsp_o.err   <= strobe & bad;
      sys_rsp_o.rdata <= rd_data;
    end
  end

  // -------------------------------------------------------------------------
  // tables and playback, one copy per channel

  for (genvar ch = 0; ch < 2; ch++) begin : g_ch
    sample_t       tbl [`RP_ASG_DEPTH];       // waveform memory
    logic [aw-1:0] ptr;                       // wraps at table depth
    sample_t       out_q;

    always_ff @(posedge adc_clk) begin
      if (sys_req_i.wen && hit_tbl[ch]) begin
        tbl[idx] <= sys_req_i.wdata[`RP_SAMPLE_W-1:0];
      end
    end

    assign tbl_rd[ch] = tbl[idx];

    always_ff @(posedge adc_clk) begin
      if (rst_i) begin
        ptr   <= '0;
        out_q <= '0;
      end else if (en[ch]) begin
        ptr   <= ptr + step[ch];              // modulo depth by width
        out_q <= tbl[ptr];                    // registered table read
      end else begin
        ptr   <= '0;                          // restart from entry 0
        out_q <= '0;
      end
    end

    assign out[ch] = out_q;
  end

  assign asg_o = '{a: out[0], b: out[1]};

endmodule

/* logic/rp_hk.sv */
// housekeeping slave with read-only ID and read/write LED register
`include "rp_params.svh"

module rp_hk
  import rp_pkg::*;
(
  input  logic       adc_clk,
  input  logic       rst_i,
  input  sys_req_t   sys_req_i,    // strobes already steered
  output sys_rsp_t   sys_rsp_o,    // registered, one cycle
  output logic [7:0] led_o         // LED pins
);

  localparam logic [`RP_REGION_LSB-1:0] id_ofs  = 'h00;  // read only
  localparam logic [`RP_REGION_LSB-1:0] led_ofs = 'h30;  // read/write

  logic [`RP_REGION_LSB-1:0] ofs;      // offset inside the region
  logic                      strobe;
  logic                      hit_id;
  logic                      hit_led;
  logic                      bad;      // undefined offset or write to ID
  logic [31:0]               rd_data;

  assign ofs     = sys_req_i.addr[`RP_REGION_LSB-1:0];
  assign strobe  = sys_req_i.wen | sys_req_i.ren;
  assign hit_id  = (ofs == id_ofs);
  assign hit_led = (ofs == led_ofs);
  assign bad     = !(hit_id || hit_led) || (sys_req_i.wen && hit_id);

  always_comb begin
    rd_data = 32'h0;                                  // writes and errors read zero
    if (sys_req_i.ren && !bad) begin
      rd_data = hit_id ? `RP_HK_ID : {24'h0, led_o};
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      led_o     <= 8'h0;                              // LEDs dark after reset
      sys_rsp_o <= '0;
    end else begin
      if (sys_req_i.wen && hit_led) begin
        led_o <= sys_req_i.wdata[7:0];
      end
      sys_rsp_o.ack   <= strobe;
      sys_rsp_o.err   <= strobe & bad;
      sys_rsp_o.rdata <= rd_data;
    end
  end

endmodule

/* logic/rp_params.svh */
// defines for sample width, system bus region map, ID value, ASG depth and controller shift
`ifndef RP_PARAMS_SVH
`define RP_PARAMS_SVH

// -------------------------------------------------------------------------
// samples

`define RP_SAMPLE_W    14              // ADC and DAC word width

// -------------------------------------------------------------------------
// system bus region map

`define RP_REGION_LSB  20              // addr[22:20] picks the region
`define RP_REGION_N    8               // regions behind the decoder
`define RP_HK_REGION   0               // housekeeping
`define RP_ASG_REGION  2               // signal generator
`define RP_PID_REGION  3               // proportional controller

`define RP_HK_ID       32'h5250_0001   // ID register contents

// signal peripherals
`define RP_ASG_DEPTH   64              // table entries per channel
`define RP_PID_SHIFT   8               // product scaling, arithmetic

`endif

/* logic/rp_pid.sv */
// two channel proportional controller with setpoint and gain registers
`include "rp_params.svh"

module rp_pid
  import rp_pkg::*;
(
  input  logic         adc_clk,
  input  logic         rst_i,
  input  sys_req_t     sys_req_i,  // strobes already steered
  output sys_rsp_t     sys_rsp_o,  // registered, one cycle
  input  sample_pair_t adc_i,      // converted ADC samples
  output sample_pair_t pid_o       // controller samples to the DAC sum
);

  localparam logic [`RP_REGION_LSB-1:0] sp_a_ofs = 'h00;  // setpoint a
  localparam logic [`RP_REGION_LSB-1:0] kp_a_ofs = 'h04;  // gain a
  localparam logic [`RP_REGION_LSB-1:0] sp_b_ofs = 'h10;
  localparam logic [`RP_REGION_LSB-1:0] kp_b_ofs = 'h14;

  localparam int smax = 2**(`RP_SAMPLE_W-1) - 1;          // +8191
  localparam int smin = -(2**(`RP_SAMPLE_W-1));           // -8192

  logic [`RP_REGION_LSB-1:0] ofs;
  logic                      strobe;
  logic [1:0]                hit_sp;   // one per channel
  logic [1:0]                hit_kp;
  logic                      bad;      // no register at this offset
  logic [31:0]               rd_data;

  sample_t                   sp [2];   // setpoints
  sample_t                   kp [2];   // gains

  // (set - x) * gain, scaled down and clipped to one sample
  function automatic sample_t p_term(sample_t set, sample_t gain, sample_t x);
    logic signed [`RP_SAMPLE_W:0]   diff;    // one bit of headroom
    logic signed [2*`RP_SAMPLE_W:0] prod;
    logic signed [2*`RP_SAMPLE_W:0] scaled;
    diff   = set - x;
    prod   = diff * gain;
    scaled = prod >>> `RP_PID_SHIFT;
    if (scaled > smax) return sample_t'(smax);
    if (scaled < smin) return sample_t'(smin);
    return scaled[`RP_SAMPLE_W-1:0];
  endfunction

  // -------------------------------------------------------------------------
  // register decode

  assign ofs    = sys_req_i.addr[`RP_REGION_LSB-1:0];
  assign strobe = sys_req_i.wen | sys_req_i.ren;
  assign hit_sp = {ofs == sp_b_ofs, ofs == sp_a_ofs};
  assign hit_kp = {ofs == kp_b_ofs, ofs == kp_a_ofs};
  assign bad    = !((|hit_sp) || (|hit_kp));

  always_comb begin
    rd_data = 32'h0;
    if (sys_req_i.ren && !bad) begin
      if (hit_sp[0])      rd_data = 32'(sp[0]);   // sign extended
      else if (hit_kp[0]) rd_data = 32'(kp[0]);
      else if (hit_sp[1]) rd_data = 32'(sp[1]);
      else                rd_data = 32'(kp[1]);
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      sp[0]     <= '0;
      sp[1]     <= '0;
      kp[0]     <= '0;                            // zero gain, zero output
      kp[1]     <= '0;
      sys_rsp_o <= '0;
    end else begin
      if (sys_req_i.wen && hit_sp[0]) sp[0] <= sys_req_i.wdata[`RP_SAMPLE_W-1:0];
      if (sys_req_i.wen && hit_kp[0]) kp[0] <= sys_req_i.wdata[`RP_SAMPLE_W-1:0];
      if (sys_req_i.wen && hit_sp[1]) sp[1] <= sys_req_i.wdata[`RP_SAMPLE_W-1:0];
      if (sys_req_i.wen && hit_kp[1]) kp[1] <= sys_req_i.wdata[`RP_SAMPLE_W-1:0];
      sys_rsp_o.ack   <= strobe;
      sys_rsp_o.err   <= strobe & bad;
      sys_rsp_o.rdata <= rd_data;
    end
  end

  // -------------------------------------------------------------------------
  // controller output, one cycle after the ADC sample

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      pid_o <= '0;
    end else begin
      pid_o <= '{a: p_term(sp[0], kp[0], adc_i.a),
                 b: p_term(sp[1], kp[1], adc_i.b)};
    end
  end

endmodule

/* logic/rp_pkg.sv */
// sample, sample pair and system bus request and response types
`include "rp_params.svh"

package rp_pkg;

  // two's complement sample as used inside the core
  typedef logic signed [`RP_SAMPLE_W-1:0] sample_t;

  typedef struct packed {
    sample_t a;                  // channel a
    sample_t b;                  // channel b
  } sample_pair_t;

  typedef struct packed {
    logic [31:0] addr;           // byte address, region in [22:20]
    logic [31:0] wdata;          // 32 bit accesses only
    logic        wen;            // one cycle write strobe
    logic        ren;            // one cycle read strobe
  } sys_req_t;

  typedef struct packed {
    logic [31:0] rdata;          // zero on writes and errors
    logic        ack;            // one cycle after the strobe
    logic        err;            // only together with ack
  } sys_rsp_t;

endpackage

/* logic/rp_sys_decoder.sv */
// system bus region decode, strobe steering, response mux and unmapped region responder
`include "rp_params.svh"

module rp_sys_decoder
  import rp_pkg::*;
(
  input  logic     adc_clk,
  input  logic     rst_i,
  input  sys_req_t sys_req_i,      // from bus master
  output sys_rsp_t sys_rsp_o,      // back to bus master
  output sys_req_t hk_req_o,       // region 0
  output sys_req_t asg_req_o,      // region 2
  output sys_req_t pid_req_o,      // region 3
  input  sys_rsp_t hk_rsp_i,
  input  sys_rsp_t asg_rsp_i,
  input  sys_rsp_t pid_rsp_i
);

  localparam int region_w = $clog2(`RP_REGION_N);  // 3 address bits

  logic [region_w-1:0] region;     // addr[22:20]
  logic                strobe;     // any access this cycle
  logic                unmapped;   // no slave behind this region
  logic                unm_ack_q;  // ack of the local responder

  // address and data go everywhere, strobes only to the selected slave
  function automatic sys_req_t steer(sys_req_t req, logic sel);
    sys_req_t r;
    r     = req;
    r.wen = req.wen & sel;
    r.ren = req.ren & sel;
    return r;
  endfunction

  // -------------------------------------------------------------------------
  // region select

  assign region   = sys_req_i.addr[`RP_REGION_LSB +: region_w];
  assign strobe   = sys_req_i.wen | sys_req_i.ren;
  assign unmapped = !(region inside {`RP_HK_REGION, `RP_ASG_REGION, `RP_PID_REGION});

  assign hk_req_o  = steer(sys_req_i, region == `RP_HK_REGION);
  assign asg_req_o = steer(sys_req_i, region == `RP_ASG_REGION);
  assign pid_req_o = steer(sys_req_i, region == `RP_PID_REGION);

  // regions 1 and 4..7 still answer, one cycle late like a slave
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      unm_ack_q <= 1'b0;
    end else begin
      unm_ack_q <= strobe & unmapped;  // zero data, never an error
    end
  end

  // -------------------------------------------------------------------------
  // response mux, address is still held in the ack cycle

  always_comb begin
    case (region)
      `RP_HK_REGION:  sys_rsp_o = hk_rsp_i;
      `RP_ASG_REGION: sys_rsp_o = asg_rsp_i;
      `RP_PID_REGION: sys_rsp_o = pid_rsp_i;
      default:        sys_rsp_o = '{rdata: 32'h0, ack: unm_ack_q, err: 1'b0};
    endcase
  end

endmodule

/* red_pitaya_top.f */
+incdir+logic
logic/rp_pkg.sv
logic/rp_sys_decoder.sv
logic/rp_hk.sv
logic/rp_asg.sv
logic/rp_pid.sv
logic/rp_analog.sv
logic/red_pitaya_top.sv
dv/red_pitaya_top_assertions.sv
dv/red_pitaya_top_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module red_pitaya_top_tb \
  -f red_pitaya_top.f -o red_pitaya_top_sim \
  && ./obj_dir/red_pitaya_top_sim > sim.log 2>&1 \
  || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "Result: PASSED" sim.log && echo "log check ok" || exit 1
